// ==== hw/axi_filter_pkg.sv ====
// AXI access filter definitions
package axi_filter_pkg;

	// ******************************
	// AXI field widths
	// ******************************
	localparam int ID_W    = 4;
	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int STRB_W  = DATA_W / 8;
	localparam int LEN_W   = 8;
	localparam int SIZE_W  = 3;
	localparam int BURST_W = 2;
	localparam int RESP_W  = 2;

	// ******************************
	// Memory operation types
	// ******************************
	// Values of the mem_op_type parameter
	localparam int MOT_READ       = 1;
	localparam int MOT_WRITE      = 2;
	localparam int MOT_READ_WRITE = 3;

	// ******************************
	// Outstanding transaction limits
	// ******************************
	localparam int CNT_W = 4;

	// Gate stops accepting new addresses at this count
	localparam logic [CNT_W-1:0] MAX_OUTSTANDING = 4'd15;

	// ******************************
	// Control FSM encoding
	// ******************************
	localparam int ST_W = 2;

	localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
	localparam logic [ST_W-1:0] ST_ACTIVE = 2'd1;
	localparam logic [ST_W-1:0] ST_DRAIN  = 2'd2;
	localparam logic [ST_W-1:0] ST_OFF    = 2'd3;

endpackage

// ==== hw/axi_addr_gate.sv ====
// AXI address channel gate
`timescale 1ns/1ps

module axi_addr_gate (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                clear,
	input  logic                                allow,
	input  logic                                full,

	// Upstream address channel
	input  logic [axi_filter_pkg::ID_W-1:0]     s_id,
	input  logic [axi_filter_pkg::ADDR_W-1:0]   s_addr,
	input  logic [axi_filter_pkg::LEN_W-1:0]    s_len,
	input  logic [axi_filter_pkg::SIZE_W-1:0]   s_size,
	input  logic [axi_filter_pkg::BURST_W-1:0]  s_burst,
	input  logic                                s_valid,
	output logic                                s_ready,

	// Downstream address channel
	output logic [axi_filter_pkg::ID_W-1:0]     m_id,
	output logic [axi_filter_pkg::ADDR_W-1:0]   m_addr,
	output logic [axi_filter_pkg::LEN_W-1:0]    m_len,
	output logic [axi_filter_pkg::SIZE_W-1:0]   m_size,
	output logic [axi_filter_pkg::BURST_W-1:0]  m_burst,
	output logic                                m_valid,
	input  logic                                m_ready,

	output logic                                accept
);

	logic draining;

	// Buffer slot frees up when the held beat leaves this cycle
	assign draining = m_valid && m_ready;

	// New beat only while allowed, below the limit, and with room
	assign s_ready = allow && !full && (!m_valid || draining);
	assign accept  = s_valid && s_ready;

	// ******************************
	// Holding register
	// ******************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_valid <= 1'b0;
		end else if (clear) begin
			m_valid <= 1'b0;
		end else if (accept) begin
			m_valid <= 1'b1;
		end else if (draining) begin
			m_valid <= 1'b0;
		end
	end

	// Payload follows the upstream beat on transfer
	always_ff @(posedge clk) begin
		if (accept) begin
			m_id    <= s_id;
			m_addr  <= s_addr;
			m_len   <= s_len;
			m_size  <= s_size;
			m_burst <= s_burst;
		end
	end

endmodule

// ==== hw/axi_outstanding_counter.sv ====
// Outstanding transaction counter
`timescale 1ns/1ps

module axi_outstanding_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic accept,
	input  logic done,
	output logic full,
	output logic idle
);

	logic [axi_filter_pkg::CNT_W-1:0] count;

	// ******************************
	// Up/down count
	// ******************************
	// Accept and done together cancel out
	// A response with nothing outstanding is ignored, so no wrap below zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (accept && !done && !full) begin
			count <= count + 1'b1;
		end else if (done && !accept && !idle) begin
			count <= count - 1'b1;
		end
	end

	assign full = (count == axi_filter_pkg::MAX_OUTSTANDING);
	assign idle = (count == '0);

endmodule

// ==== hw/axi_filter_ctrl.sv ====
// Access filter control FSM
`timescale 1ns/1ps

module axi_filter_ctrl #(
	parameter int mem_op_type = axi_filter_pkg::MOT_READ_WRITE
) (
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic en,
	input  logic rd_idle,
	input  logic wr_idle,
	output logic rd_allow,
	output logic wr_allow,
	output logic drained
);

	logic [axi_filter_pkg::ST_W-1:0] state;
	logic [axi_filter_pkg::ST_W-1:0] state_next;
	logic                            rd_ok;
	logic                            wr_ok;

	// Directions permitted by the operation type
	assign rd_ok = (mem_op_type == axi_filter_pkg::MOT_READ) ||
		(mem_op_type == axi_filter_pkg::MOT_READ_WRITE);
	assign wr_ok = (mem_op_type == axi_filter_pkg::MOT_WRITE) ||
		(mem_op_type == axi_filter_pkg::MOT_READ_WRITE);

	// ******************************
	// Next state
	// ******************************
	always_comb begin
		state_next = state;
		case (state)
			axi_filter_pkg::ST_IDLE: begin
				if (en) begin
					state_next = axi_filter_pkg::ST_ACTIVE;
				end
			end
			axi_filter_pkg::ST_ACTIVE: begin
				if (!en) begin
					state_next = axi_filter_pkg::ST_DRAIN;
				end
			end
			// Wait for every accepted transaction to be answered
			axi_filter_pkg::ST_DRAIN: begin
				if (rd_idle && wr_idle) begin
					state_next = axi_filter_pkg::ST_OFF;
				end
			end
			axi_filter_pkg::ST_OFF: begin
				if (en) begin
					state_next = axi_filter_pkg::ST_ACTIVE;
				end
			end
			default: begin
				state_next = axi_filter_pkg::ST_IDLE;
			end
		endcase
	end

	// ******************************
	// State and drained flag
	// ******************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= axi_filter_pkg::ST_IDLE;
			drained <= 1'b0;
		end else if (clear) begin
			state   <= axi_filter_pkg::ST_IDLE;
			drained <= 1'b0;
		end else begin
			state   <= state_next;
			// Rises with entry to OFF, or one cycle into IDLE
			drained <= (state_next == axi_filter_pkg::ST_OFF) ||
				((state == axi_filter_pkg::ST_IDLE) && (state_next == axi_filter_pkg::ST_IDLE));
		end
	end

	assign rd_allow = (state == axi_filter_pkg::ST_ACTIVE) && rd_ok;
	assign wr_allow = (state == axi_filter_pkg::ST_ACTIVE) && wr_ok;

endmodule

// ==== hw/axi_access_filter.sv ====
// AXI access filter top level
`timescale 1ns/1ps

module axi_access_filter #(
	parameter int mem_op_type = axi_filter_pkg::MOT_READ_WRITE
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                clear,
	input  logic                                en,
	output logic                                drained,

	// Upstream read address
	input  logic [axi_filter_pkg::ID_W-1:0]     s_arid,
	input  logic [axi_filter_pkg::ADDR_W-1:0]   s_araddr,
	input  logic [axi_filter_pkg::LEN_W-1:0]    s_arlen,
	input  logic [axi_filter_pkg::SIZE_W-1:0]   s_arsize,
	input  logic [axi_filter_pkg::BURST_W-1:0]  s_arburst,
	input  logic                                s_arvalid,
	output logic                                s_arready,

	// Upstream read data
	output logic [axi_filter_pkg::ID_W-1:0]     s_rid,
	output logic [axi_filter_pkg::DATA_W-1:0]   s_rdata,
	output logic [axi_filter_pkg::RESP_W-1:0]   s_rresp,
	output logic                                s_rlast,
	output logic                                s_rvalid,
	input  logic                                s_rready,

	// Upstream write address
	input  logic [axi_filter_pkg::ID_W-1:0]     s_awid,
	input  logic [axi_filter_pkg::ADDR_W-1:0]   s_awaddr,
	input  logic [axi_filter_pkg::LEN_W-1:0]    s_awlen,
	input  logic [axi_filter_pkg::SIZE_W-1:0]   s_awsize,
	input  logic [axi_filter_pkg::BURST_W-1:0]  s_awburst,
	input  logic                                s_awvalid,
	output logic                                s_awready,

	// Upstream write data
	input  logic [axi_filter_pkg::ID_W-1:0]     s_wid,
	input  logic [axi_filter_pkg::DATA_W-1:0]   s_wdata,
	input  logic [axi_filter_pkg::STRB_W-1:0]   s_wstrb,
	input  logic                                s_wlast,
	input  logic                                s_wvalid,
	output logic                                s_wready,

	// Upstream write response
	output logic [axi_filter_pkg::ID_W-1:0]     s_bid,
	output logic [axi_filter_pkg::RESP_W-1:0]   s_bresp,
	output logic                                s_bvalid,
	input  logic                                s_bready,

	// Downstream read address
	output logic [axi_filter_pkg::ID_W-1:0]     m_arid,
	output logic [axi_filter_pkg::ADDR_W-1:0]   m_araddr,
	output logic [axi_filter_pkg::LEN_W-1:0]    m_arlen,
	output logic [axi_filter_pkg::SIZE_W-1:0]   m_arsize,
	output logic [axi_filter_pkg::BURST_W-1:0]  m_arburst,
	output logic                                m_arvalid,
	input  logic                                m_arready,

	// Downstream read data
	input  logic [axi_filter_pkg::ID_W-1:0]     m_rid,
	input  logic [axi_filter_pkg::DATA_W-1:0]   m_rdata,
	input  logic [axi_filter_pkg::RESP_W-1:0]   m_rresp,
	input  logic                                m_rlast,
	input  logic                                m_rvalid,
	output logic                                m_rready,

	// Downstream write address
	output logic [axi_filter_pkg::ID_W-1:0]     m_awid,
	output logic [axi_filter_pkg::ADDR_W-1:0]   m_awaddr,
	output logic [axi_filter_pkg::LEN_W-1:0]    m_awlen,
	output logic [axi_filter_pkg::SIZE_W-1:0]   m_awsize,
	output logic [axi_filter_pkg::BURST_W-1:0]  m_awburst,
	output logic                                m_awvalid,
	input  logic                                m_awready,

	// Downstream write data
	output logic [axi_filter_pkg::ID_W-1:0]     m_wid,
	output logic [axi_filter_pkg::DATA_W-1:0]   m_wdata,
	output logic [axi_filter_pkg::STRB_W-1:0]   m_wstrb,
	output logic                                m_wlast,
	output logic                                m_wvalid,
	input  logic                                m_wready,

	// Downstream write response
	input  logic [axi_filter_pkg::ID_W-1:0]     m_bid,
	input  logic [axi_filter_pkg::RESP_W-1:0]   m_bresp,
	input  logic                                m_bvalid,
	output logic                                m_bready
);

	logic rd_allow;
	logic wr_allow;
	logic ar_accept;
	logic aw_accept;
	logic rd_full;
	logic wr_full;
	logic rd_idle;
	logic wr_idle;
	logic rd_done;
	logic wr_done;

	// ******************************
	// Control
	// ******************************
	axi_filter_ctrl #(
		.mem_op_type(mem_op_type)
	) i_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.clear   (clear),
		.en      (en),
		.rd_idle (rd_idle),
		.wr_idle (wr_idle),
		.rd_allow(rd_allow),
		.wr_allow(wr_allow),
		.drained (drained)
	);

	// ******************************
	// Read direction
	// ******************************
	axi_addr_gate i_ar_gate (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (clear),
		.allow  (rd_allow),
		.full   (rd_full),
		.s_id   (s_arid),
		.s_addr (s_araddr),
		.s_len  (s_arlen),
		.s_size (s_arsize),
		.s_burst(s_arburst),
		.s_valid(s_arvalid),
		.s_ready(s_arready),
		.m_id   (m_arid),
		.m_addr (m_araddr),
		.m_len  (m_arlen),
		.m_size (m_arsize),
		.m_burst(m_arburst),
		.m_valid(m_arvalid),
		.m_ready(m_arready),
		.accept (ar_accept)
	);

	// A read completes with its last data beat
	assign rd_done = m_rvalid && m_rready && m_rlast;

	axi_outstanding_counter i_rd_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.clear (clear),
		.accept(ar_accept),
		.done  (rd_done),
		.full  (rd_full),
		.idle  (rd_idle)
	);

	assign s_rid    = m_rid;
	assign s_rdata  = m_rdata;
	assign s_rresp  = m_rresp;
	assign s_rlast  = m_rlast;
	assign s_rvalid = m_rvalid;
	assign m_rready = s_rready;

	// ******************************
	// Write direction
	// ******************************
	axi_addr_gate i_aw_gate (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (clear),
		.allow  (wr_allow),
		.full   (wr_full),
		.s_id   (s_awid),
		.s_addr (s_awaddr),
		.s_len  (s_awlen),
		.s_size (s_awsize),
		.s_burst(s_awburst),
		.s_valid(s_awvalid),
		.s_ready(s_awready),
		.m_id   (m_awid),
		.m_addr (m_awaddr),
		.m_len  (m_awlen),
		.m_size (m_awsize),
		.m_burst(m_awburst),
		.m_valid(m_awvalid),
		.m_ready(m_awready),
		.accept (aw_accept)
	);

	// A write completes with its B handshake
	assign wr_done = m_bvalid && m_bready;

	axi_outstanding_counter i_wr_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.clear (clear),
		.accept(aw_accept),
		.done  (wr_done),
		.full  (wr_full),
		.idle  (wr_idle)
	);

	// W and B pass straight through
	assign m_wid    = s_wid;
	assign m_wdata  = s_wdata;
	assign m_wstrb  = s_wstrb;
	assign m_wlast  = s_wlast;
	assign m_wvalid = s_wvalid;
	assign s_wready = m_wready;

	assign s_bid    = m_bid;
	assign s_bresp  = m_bresp;
	assign s_bvalid = m_bvalid;
	assign m_bready = s_bready;

endmodule

// ==== bench/tb_axi_access_filter.sv ====
// AXI access filter testbench
`timescale 1ns/1ps

module tb_axi_access_filter;

	localparam int TIMEOUT    = 200;
	localparam int BLOCK_WAIT = 40;

	logic clk, rst_n, clear, en, drained;

	logic [axi_filter_pkg::ID_W-1:0]    s_arid, s_rid, s_awid, s_wid, s_bid;
	logic [axi_filter_pkg::ID_W-1:0]    m_arid, m_rid, m_awid, m_wid, m_bid;
	logic [axi_filter_pkg::ADDR_W-1:0]  s_araddr, s_awaddr, m_araddr, m_awaddr;
	logic [axi_filter_pkg::LEN_W-1:0]   s_arlen, s_awlen, m_arlen, m_awlen;
	logic [axi_filter_pkg::SIZE_W-1:0]  s_arsize, s_awsize, m_arsize, m_awsize;
	logic [axi_filter_pkg::BURST_W-1:0] s_arburst, s_awburst, m_arburst, m_awburst;
	logic [axi_filter_pkg::DATA_W-1:0]  s_rdata, s_wdata, m_rdata, m_wdata;
	logic [axi_filter_pkg::STRB_W-1:0]  s_wstrb, m_wstrb;
	logic [axi_filter_pkg::RESP_W-1:0]  s_rresp, s_bresp, m_rresp, m_bresp;
	logic s_arvalid, s_arready, s_rlast, s_rvalid, s_rready;
	logic s_awvalid, s_awready, s_wlast, s_wvalid, s_wready, s_bvalid, s_bready;
	logic m_arvalid, m_arready, m_rlast, m_rvalid, m_rready;
	logic m_awvalid, m_awready, m_wlast, m_wvalid, m_wready, m_bvalid, m_bready;

	// Responder state
	logic [31:0] lfsr;
	logic        rd_busy, wr_busy;
	logic [3:0]  rd_id, wr_id;
	logic [31:0] rd_addr, wr_addr;
	logic [7:0]  rd_len, wr_len;
	logic [8:0]  rd_beat, wr_beat;

	// Stimulus sets the expected address beat before valid rises
	logic [3:0]  exp_id;
	logic [31:0] exp_addr;
	logic [7:0]  exp_len;

	int ar_seen = 0;
	int aw_seen = 0;
	int rd_total = 0;
	int wr_total = 0;
	int val_errs = 0;
	int other_errs = 0;

	axi_access_filter i_axi_access_filter (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp === got) else begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			val_errs++;
		end
	endtask

	// ******************************
	// Downstream slave model
	// ******************************
	always @(posedge clk) begin
		if (!rst_n) begin
			m_arready <= 1'b0;
			m_awready <= 1'b0;
			m_wready  <= 1'b0;
			m_rvalid  <= 1'b0;
			m_rlast   <= 1'b0;
			m_bvalid  <= 1'b0;
			rd_busy   <= 1'b0;
			wr_busy   <= 1'b0;
		end else begin
			if (m_arvalid && m_arready) begin
				check_val("m_arid", exp_id, m_arid);
				check_val("m_araddr", exp_addr, m_araddr);
				check_val("m_arlen", exp_len, m_arlen);
				check_val("m_arsize", 2, m_arsize);
				check_val("m_arburst", 1, m_arburst);
				ar_seen <= ar_seen + 1;
				rd_busy <= 1'b1;
				rd_id   <= m_arid;
				rd_addr <= m_araddr;
				rd_len  <= m_arlen;
				rd_beat <= '0;
			end
			lfsr = lfsr_next(lfsr);
			m_arready <= lfsr[0] && !rd_busy && !(m_arvalid && m_arready);

			// One read data beat per handshake
			if (rd_busy && (!m_rvalid || m_rready)) begin
				if (m_rvalid && m_rlast) begin
					m_rvalid <= 1'b0;
					m_rlast  <= 1'b0;
					rd_busy  <= 1'b0;
				end else begin
					m_rvalid <= 1'b1;
					m_rid    <= rd_id;
					m_rdata  <= rd_addr + rd_beat;
					m_rresp  <= 2'b00;
					m_rlast  <= (rd_beat == rd_len);
					rd_beat  <= rd_beat + 1'b1;
				end
			end

			if (m_awvalid && m_awready) begin
				check_val("m_awid", exp_id, m_awid);
				check_val("m_awaddr", exp_addr, m_awaddr);
				check_val("m_awlen", exp_len, m_awlen);
				check_val("m_awsize", 2, m_awsize);
				check_val("m_awburst", 1, m_awburst);
				aw_seen <= aw_seen + 1;
				wr_busy <= 1'b1;
				wr_id   <= m_awid;
				wr_addr <= m_awaddr;
				wr_len  <= m_awlen;
				wr_beat <= '0;
			end
			lfsr = lfsr_next(lfsr);
			m_awready <= lfsr[0] && !wr_busy && !(m_awvalid && m_awready);

			if (m_wvalid && m_wready) begin
				check_val("m_wid", wr_id, m_wid);
				check_val("m_wdata", wr_addr + wr_beat, m_wdata);
				check_val("m_wstrb", 4'hf, m_wstrb);
				check_val("m_wlast", wr_beat == wr_len, m_wlast);
				wr_beat <= wr_beat + 1'b1;
				if (m_wlast) begin
					m_bvalid <= 1'b1;
					m_bid    <= wr_id;
					m_bresp  <= 2'b00;
				end
			end
			lfsr = lfsr_next(lfsr);
			m_wready <= lfsr[0] && wr_busy && !m_bvalid && !(m_wvalid && m_wready && m_wlast);

			if (m_bvalid && m_bready) begin
				m_bvalid <= 1'b0;
				wr_busy  <= 1'b0;
			end
		end
	end

	// ******************************
	// Stimulus tasks
	// ******************************
	task automatic apply_en(input int en_v);
		int n;
		n = 0;
		if (en && en_v == 0) begin
			en <= 1'b0;
			while (!drained && n < TIMEOUT) begin
				@(posedge clk);
				n++;
			end
			assert (drained) else begin
				$display("drained did not rise after en fell");
				other_errs++;
			end
		end else if (!en && en_v != 0) begin
			en <= 1'b1;
			while (drained && n < TIMEOUT) begin
				@(posedge clk);
				n++;
			end
			assert (!drained) else begin
				$display("drained did not fall after en returned");
				other_errs++;
			end
		end
	endtask

	task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
		input logic [7:0] len, input int expect_ok);
		int n;
		int beat;
		logic got;
		logic done;
		exp_id = id;
		exp_addr = addr;
		exp_len = len;
		s_arid    <= id;
		s_araddr  <= addr;
		s_arlen   <= len;
		s_arsize  <= 3'd2;
		s_arburst <= 2'd1;
		s_arvalid <= 1'b1;
		got = 0;
		n = 0;
		while (!got && n < (expect_ok ? TIMEOUT : BLOCK_WAIT)) begin
			@(posedge clk);
			n++;
			if (s_arvalid && s_arready) begin
				got = 1;
			end
		end
		s_arvalid <= 1'b0;
		if (!expect_ok) begin
			assert (!got) else begin
				$display("A read was accepted while reads were disabled");
				other_errs++;
			end
			return;
		end
		assert (got) else begin
			$display("Timed out waiting for the read address to be accepted");
			other_errs++;
		end
		if (!got) return;
		check_val("drained", 0, drained);
		rd_total++;
		beat = 0;
		done = 0;
		n = 0;
		while (!done && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			if (s_rvalid && s_rready) begin
				check_val("s_rdata", addr + beat, s_rdata);
				check_val("s_rid", id, s_rid);
				check_val("s_rresp", 0, s_rresp);
				check_val("s_rlast", beat == len, s_rlast);
				done = s_rlast;
				beat++;
			end
		end
		assert (done) else begin
			$display("Timed out waiting for the last read data beat");
			other_errs++;
		end
		check_val("read address count", rd_total, ar_seen);
	endtask

	task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
		input logic [7:0] len, input int expect_ok);
		int n;
		int beat;
		logic got;
		exp_id = id;
		exp_addr = addr;
		exp_len = len;
		s_awid    <= id;
		s_awaddr  <= addr;
		s_awlen   <= len;
		s_awsize  <= 3'd2;
		s_awburst <= 2'd1;
		s_awvalid <= 1'b1;
		got = 0;
		n = 0;
		while (!got && n < (expect_ok ? TIMEOUT : BLOCK_WAIT)) begin
			@(posedge clk);
			n++;
			if (s_awvalid && s_awready) begin
				got = 1;
			end
		end
		s_awvalid <= 1'b0;
		if (!expect_ok) begin
			assert (!got) else begin
				$display("A write was accepted while writes were disabled");
				other_errs++;
			end
			return;
		end
		assert (got) else begin
			$display("Timed out waiting for the write address to be accepted");
			other_errs++;
		end
		if (!got) return;
		wr_total++;
		for (beat = 0; beat <= len; beat++) begin
			s_wvalid <= 1'b1;
			s_wid    <= id;
			s_wdata  <= addr + beat;
			s_wstrb  <= 4'hf;
			s_wlast  <= (beat == len);
			got = 0;
			n = 0;
			while (!got && n < TIMEOUT) begin
				@(posedge clk);
				n++;
				got = s_wvalid && s_wready;
			end
			assert (got) else begin
				$display("Timed out waiting for a write data beat to be taken");
				other_errs++;
			end
		end
		s_wvalid <= 1'b0;
		s_wlast  <= 1'b0;
		got = 0;
		n = 0;
		while (!got && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			if (s_bvalid && s_bready) begin
				got = 1;
				check_val("s_bid", id, s_bid);
				check_val("s_bresp", 0, s_bresp);
			end
		end
		assert (got) else begin
			$display("Timed out waiting for the write response");
			other_errs++;
		end
		check_val("write address count", wr_total, aw_seen);
	endtask

	// After a clear pulse drained follows its after-reset pattern
	task automatic pulse_clear();
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		@(posedge clk);
		check_val("drained", 0, drained);
		@(posedge clk);
		check_val("drained", 1, drained);
	endtask

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		int fd;
		int cnt;
		string line;
		byte op;
		int id_v, addr_v, len_v, en_v, exp_v;
		clk = 1'b0;
		rst_n = 1'b0;
		clear = 1'b0;
		en = 1'b0;
		lfsr = 32'h769a;
		s_arvalid = 1'b0;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_wlast = 1'b0;
		s_rready = 1'b1;
		s_bready = 1'b1;
		{s_arid, s_araddr, s_arlen, s_arsize, s_arburst} = '0;
		{s_awid, s_awaddr, s_awlen, s_awsize, s_awburst} = '0;
		{s_wid, s_wdata, s_wstrb} = '0;
		{m_rid, m_rdata, m_rresp, m_bid, m_bresp} = '0;
		{m_arready, m_awready, m_wready, m_rvalid, m_rlast, m_bvalid} = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		fd = $fopen("bench/axi_filter_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			other_errs++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cnt = $fgets(line, fd);
				if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%c %h %h %h %d %d",
						op, id_v, addr_v, len_v, en_v, exp_v);
					if (cnt != 6) begin
						$display("Malformed test data line: %s", line);
						other_errs++;
					end else begin
						apply_en(en_v);
						if (op == "R") read_burst(id_v, addr_v, len_v, exp_v);
						else if (op == "W") write_burst(id_v, addr_v, len_v, exp_v);
						else if (op == "C") pulse_clear();
					end
				end
			end
			$fclose(fd);
		end
		repeat (4) @(posedge clk);
		$display("Errors: %0d wrong values, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== bench/axi_filter_testdata.txt ====
# op id addr len en expect   (hex id, addr, len; decimal en and expect)
# op R read, W write, C clear pulse; expect 1 accepted, 0 blocked
R 1 00001000 00 1 1
R 2 00002000 03 1 1
W 3 00003000 00 1 1
W 4 00004000 07 1 1
R 5 00005010 01 1 1
W 6 00006020 02 1 1
R 7 00007000 0f 1 1
W 8 00008000 0f 1 1
R 9 0000a000 05 1 1
W a 0000b000 03 1 1
R b 10000000 00 1 1
W c 20000000 00 1 1
R d fffff000 02 1 1
W e 12345678 01 1 1
R 0 00000000 00 0 0
W 1 00000100 01 0 0
R 2 00000200 02 0 0
R 3 0000c000 02 1 1
W 4 0000d000 04 1 1
R 5 0000e000 00 1 1
W 6 0000f000 00 0 0
R 7 00011000 03 0 0
W 8 00012000 05 1 1
R 9 00013000 06 1 1
C 0 00000000 00 0 0
R a 00014000 01 1 1
W b 00015000 02 1 1
R c 00016000 07 1 1
W d 00017000 00 0 0
C 0 00000000 00 0 0
W e 00018000 03 1 1
R f 00019000 04 1 1
W f 0001a000 01 1 1
R 1 0001b000 00 1 1
W 2 0001c000 0a 1 1
R 3 0001d000 0b 1 1
R 4 0001e000 00 0 0
W 5 0001f000 00 0 0

// ==== vlog.f ====
hw/axi_filter_pkg.sv
hw/axi_addr_gate.sv
hw/axi_outstanding_counter.sv
hw/axi_filter_ctrl.sv
hw/axi_access_filter.sv
bench/tb_axi_access_filter.sv
